/* common/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// address, data and tag ("nick") widths of the load/store path.
`define ADDR_W 17
`define DATA_W 32
`define TAG_W 4

// width of the per-byte wait-cycle count of the memory controller.
`define WAIT_W 2

// number of entries in the load/store buffer.
`define LSB_DEPTH 4

// size of the memory controller RAM in bytes.
// addresses wrap modulo this size.
`define RAM_BYTES 256

`endif

/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // direction of a memory request.
    typedef enum logic {
        opLoad,
        opStore
    } memOp;

    // access length of 1, 2 or 4 bytes.
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen;

    // memory controller states.
    // mcWait and mcXfer alternate once per byte.
    typedef enum logic [1:0] {
        mcIdle,
        mcWait,
        mcXfer,
        mcDone
    } mcState;

endpackage

`default_nettype wire

/* hdl/loadStoreBuffer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lsu_config.svh"

module loadStoreBuffer
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic               reqEn,
    input  memOp               reqOp,
    input  logic [`ADDR_W-1:0] reqAddr,
    input  logic [`DATA_W-1:0] reqData,
    input  accessLen           reqLen,
    input  logic [`TAG_W-1:0]  reqTag,
    output logic               reqReady,

    input  logic               cacheReady,
    output logic               issueEn,
    output memOp               issueOp,
    output logic [`ADDR_W-1:0] issueAddr,
    output logic [`DATA_W-1:0] issueData,
    output accessLen           issueLen,
    output logic [`TAG_W-1:0]  issueTag
);

    localparam int DEPTH = `LSB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    memOp               opMem   [DEPTH];
    logic [`ADDR_W-1:0] addrMem [DEPTH];
    logic [`DATA_W-1:0] dataMem [DEPTH];
    accessLen           lenMem  [DEPTH];
    logic [`TAG_W-1:0]  tagMem  [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             outOfReset;
    logic             issueStb;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign reqReady = outOfReset && rdy && (count != CNT_W'(DEPTH));
    assign push     = reqEn && reqReady;

    // the dcache raises occupied one cycle after an issue, so a pending
    // issue strobe blocks the next pop.
    assign pop = (count != '0) && cacheReady && !issueStb;

    // the strobe register freezes with rdy low and reappears once rdy returns.
    assign issueEn = issueStb && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            issueStb   <= 1'b0;
            outOfReset <= 1'b0;
        end else begin
            outOfReset <= 1'b1;
            if (rdy) begin
                issueStb <= pop;
                if (push) begin
                    tail <= nextPtr(tail);
                end
                if (pop) begin
                    head <= nextPtr(head);
                end
                if (push && !pop) begin
                    count <= count + 1'b1;
                end else if (pop && !push) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[tail]   <= reqOp;
            addrMem[tail] <= reqAddr;
            dataMem[tail] <= reqData;
            lenMem[tail]  <= reqLen;
            tagMem[tail]  <= reqTag;
        end
        if (pop) begin
            issueOp   <= opMem[head];
            issueAddr <= addrMem[head];
            issueData <= dataMem[head];
            issueLen  <= lenMem[head];
            issueTag  <= tagMem[head];
        end
    end

    // the core only strobes a request while the buffer has room.
    assert property (@(posedge clk) disable iff (rst) reqEn |-> reqReady)
        else $error("loadStoreBuffer: request strobed while buffer full or not ready");

endmodule

`default_nettype wire

/* dcache/dcache.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lsu_config.svh"

module dcache
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic               issueEn,
    input  memOp               issueOp,
    input  logic [`ADDR_W-1:0] issueAddr,
    input  logic [`DATA_W-1:0] issueData,
    input  accessLen           issueLen,
    input  logic [`TAG_W-1:0]  issueTag,
    output logic               cacheReady,

    input  logic               mcDone,
    input  logic [`DATA_W-1:0] mcRdata,
    output logic               mcEn,
    output memOp               mcOp,
    output logic [`ADDR_W-1:0] mcAddr,
    output logic [`DATA_W-1:0] mcData,
    output accessLen           mcLen,

    output logic               respDone,
    output logic [`DATA_W-1:0] respData,
    output logic [`TAG_W-1:0]  respTag
);

    logic              occupied;
    logic              outOfReset;
    logic              mcStb;
    logic              respStb;
    logic [`TAG_W-1:0] savedTag;

    assign cacheReady = outOfReset && rdy && !occupied;
    assign mcEn       = mcStb && rdy;
    assign respDone   = respStb && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied   <= 1'b0;
            outOfReset <= 1'b0;
            mcStb      <= 1'b0;
            respStb    <= 1'b0;
        end else begin
            outOfReset <= 1'b1;
            if (rdy) begin
                mcStb   <= issueEn;
                respStb <= mcDone;
                if (issueEn) begin
                    occupied <= 1'b1;
                end else if (mcDone) begin
                    occupied <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn) begin
            mcOp     <= issueOp;
            mcAddr   <= issueAddr;
            mcData   <= issueData;
            mcLen    <= issueLen;
            savedTag <= issueTag;
        end
        if (mcDone) begin
            respData <= mcRdata;
            respTag  <= savedTag;
        end
    end

    // the buffer waits for cacheReady, so a second request never overlaps.
    assert property (@(posedge clk) disable iff (rst) issueEn |-> !occupied)
        else $error("dcache: issue received while a request is outstanding");

    // memory only completes a request that this stage forwarded.
    assert property (@(posedge clk) disable iff (rst) mcDone |-> occupied)
        else $error("dcache: memory completion with no request outstanding");

endmodule

`default_nettype wire

/* memCtrl/memCtrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lsu_config.svh"

module memCtrl
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic [`WAIT_W-1:0] memWait,

    input  logic               mcEn,
    input  memOp               mcOp,
    input  logic [`ADDR_W-1:0] mcAddr,
    input  logic [`DATA_W-1:0] mcData,
    input  accessLen           mcLen,
    output logic               mcDone,
    output logic [`DATA_W-1:0] mcRdata
);

    localparam int RAM_AW = $clog2(`RAM_BYTES);

    logic [7:0] ram [`RAM_BYTES];

    mcState             state;
    logic [1:0]         byteIdx;
    logic [`WAIT_W-1:0] waitCnt;

    memOp               opReg;
    accessLen           lenReg;
    logic [RAM_AW-1:0]  addrReg;
    logic [`DATA_W-1:0] dataReg;
    logic [RAM_AW-1:0]  ramIdx;
    logic               lastByte;

    // a byte skips the wait state entirely when no wait cycles are set.
    function automatic mcState byteEntry(input logic [`WAIT_W-1:0] waitCycles);
        return (waitCycles == '0) ? mcXfer : mcWait;
    endfunction

    function automatic logic [1:0] lastIndex(input accessLen len);
        case (len)
            lenByte: return 2'd0;
            lenHalf: return 2'd1;
            default: return 2'd3;
        endcase
    endfunction

    // the byte address wraps around the RAM.
    assign ramIdx   = addrReg + RAM_AW'(byteIdx);
    assign lastByte = (byteIdx == lastIndex(lenReg));

    assign mcDone = (state == lsu_pkg::mcDone) && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mcIdle;
            byteIdx <= '0;
            waitCnt <= '0;
        end else if (rdy) begin
            case (state)
                mcIdle: begin
                    if (mcEn) begin
                        byteIdx <= '0;
                        waitCnt <= memWait - 1'b1;
                        state   <= byteEntry(memWait);
                    end
                end
                mcWait: begin
                    if (waitCnt == '0) begin
                        state <= mcXfer;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                mcXfer: begin
                    if (lastByte) begin
                        state <= lsu_pkg::mcDone;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                        waitCnt <= memWait - 1'b1;
                        state   <= byteEntry(memWait);
                    end
                end
                default: begin
                    state <= mcIdle;
                end
            endcase
        end
    end

    // request latch and load data assembly.
    // load data starts at zero, which zero-extends short loads and stores.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == mcIdle && mcEn) begin
                opReg   <= mcOp;
                lenReg  <= mcLen;
                addrReg <= mcAddr[RAM_AW-1:0];
                dataReg <= mcData;
                mcRdata <= '0;
            end else if (state == mcXfer && opReg == opLoad) begin
                mcRdata[{byteIdx, 3'b000} +: 8] <= ram[ramIdx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state == mcXfer && opReg == opStore) begin
            ram[ramIdx] <= dataReg[{byteIdx, 3'b000} +: 8];
        end
    end

    // the dcache keeps a single request in flight.
    assert property (@(posedge clk) disable iff (rst) mcEn |-> state == mcIdle)
        else $error("memCtrl: request received while busy");

endmodule

`default_nettype wire

/* hdl/lsuTop.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lsu_config.svh"

module lsuTop
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic [`WAIT_W-1:0] memWait,

    input  logic               reqEn,
    input  memOp               reqOp,
    input  logic [`ADDR_W-1:0] reqAddr,
    input  logic [`DATA_W-1:0] reqData,
    input  accessLen           reqLen,
    input  logic [`TAG_W-1:0]  reqTag,
    output logic               reqReady,

    output logic               respDone,
    output logic [`DATA_W-1:0] respData,
    output logic [`TAG_W-1:0]  respTag
);

    // buffer to dcache.
    logic               cacheReady;
    logic               issueEn;
    memOp               issueOp;
    logic [`ADDR_W-1:0] issueAddr;
    logic [`DATA_W-1:0] issueData;
    accessLen           issueLen;
    logic [`TAG_W-1:0]  issueTag;

    // dcache to memory controller.
    logic               mcEn;
    memOp               mcOp;
    logic [`ADDR_W-1:0] mcAddr;
    logic [`DATA_W-1:0] mcData;
    accessLen           mcLen;
    logic               mcDone;
    logic [`DATA_W-1:0] mcRdata;

    loadStoreBuffer u_loadStoreBuffer (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .reqEn      (reqEn),
        .reqOp      (reqOp),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .reqLen     (reqLen),
        .reqTag     (reqTag),
        .reqReady   (reqReady),
        .cacheReady (cacheReady),
        .issueEn    (issueEn),
        .issueOp    (issueOp),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueTag   (issueTag)
    );

    dcache u_dcache (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueEn    (issueEn),
        .issueOp    (issueOp),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueTag   (issueTag),
        .cacheReady (cacheReady),
        .mcDone     (mcDone),
        .mcRdata    (mcRdata),
        .mcEn       (mcEn),
        .mcOp       (mcOp),
        .mcAddr     (mcAddr),
        .mcData     (mcData),
        .mcLen      (mcLen),
        .respDone   (respDone),
        .respData   (respData),
        .respTag    (respTag)
    );

    memCtrl u_memCtrl (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .memWait (memWait),
        .mcEn    (mcEn),
        .mcOp    (mcOp),
        .mcAddr  (mcAddr),
        .mcData  (mcData),
        .mcLen   (mcLen),
        .mcDone  (mcDone),
        .mcRdata (mcRdata)
    );

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // the clock runs freely and rises first after half a period.
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* testbench/lsuTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lsu_config.svh"

module lsuTb
    import lsu_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int READY_WAIT   = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int DRAIN_CYCLES = 10;
    localparam int DRIVE_DELAY  = 10;
    localparam int SETTLE       = 1;
    localparam int COLS         = 7;
    localparam int MAX_VECS     = 32;
    // worst case per request is four bytes at the largest wait count.
    localparam int CYCLES_PER_VEC = 4 * (3 + 1) + 8;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic [`WAIT_W-1:0] memWait;
    logic               reqEn;
    memOp               reqOp;
    logic [`ADDR_W-1:0] reqAddr;
    logic [`DATA_W-1:0] reqData;
    accessLen           reqLen;
    logic [`TAG_W-1:0]  reqTag;
    logic               reqReady;
    logic               respDone;
    logic [`DATA_W-1:0] respData;
    logic [`TAG_W-1:0]  respTag;

    logic [31:0]        vecMem [MAX_VECS * COLS];
    int                 vecCount;
    bit                 vectorsLoaded;
    bit                 sawFull;
    int                 respCount;
    logic [`DATA_W-1:0] expData [$];
    logic [`TAG_W-1:0]  expTag [$];
    logic [`DATA_W-1:0] headData;
    logic [`TAG_W-1:0]  headTag;

    tbClock #(.PERIOD(100)) u_tbClock (
        .clk (clk)
    );

    lsuTop u_lsuTop (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memWait  (memWait),
        .reqEn    (reqEn),
        .reqOp    (reqOp),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqLen   (reqLen),
        .reqTag   (reqTag),
        .reqReady (reqReady),
        .respDone (respDone),
        .respData (respData),
        .respTag  (respTag)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input logic [`DATA_W-1:0] expected,
                             input logic [`DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkTag(input string name, input logic [`TAG_W-1:0] expected,
                            input logic [`TAG_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // unused slots hold the complement of their index, which is never a valid op
    // and so marks the end of the file.
    task automatic loadVectors();
        int i;
        for (i = 0; i < MAX_VECS * COLS; i++) begin
            vecMem[i] = ~32'(i);
        end
        $readmemh("testbench/lsu_vectors.txt", vecMem);
        vecCount = 0;
        while (vecCount < MAX_VECS && vecMem[vecCount * COLS] <= 32'd1) begin
            vecCount++;
        end
    endtask

    // rdy is low in roughly one cycle out of eight.
    function automatic logic randomRdy();
        return ($urandom % 8) != 0;
    endfunction

    task automatic idleCycle();
        @(posedge clk);
        #DRIVE_DELAY;
        reqEn = 1'b0;
        rdy   = randomRdy();
    endtask

    task automatic pushRequest(input int idx);
        int base;
        bit accepted;
        base     = idx * COLS;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            #DRIVE_DELAY;
            reqEn   = 1'b0;
            rdy     = randomRdy();
            memWait = vecMem[base + 6][`WAIT_W-1:0];
            #SETTLE;
            if (reqReady) begin
                reqEn   = 1'b1;
                reqOp   = memOp'(vecMem[base][0]);
                reqAddr = vecMem[base + 1][`ADDR_W-1:0];
                reqData = vecMem[base + 2];
                reqLen  = accessLen'(vecMem[base + 3][1:0]);
                reqTag  = vecMem[base + 4][`TAG_W-1:0];
                expData.push_back(vecMem[base + 5]);
                expTag.push_back(vecMem[base + 4][`TAG_W-1:0]);
                accepted = 1'b1;
            end else if (rdy) begin
                // with rdy high, a low reqReady can only mean a full buffer.
                sawFull = 1'b1;
            end
        end
    endtask

    // responses are sampled mid-cycle, away from both drive and clock edges.
    always @(negedge clk) begin
        if (!rst && respDone) begin
            if (expData.size() == 0) begin
                reportFailure("response arrived with no request outstanding");
            end else begin
                headData = expData.pop_front();
                headTag  = expTag.pop_front();
                checkData($sformatf("response %0d data", respCount), headData, respData);
                checkTag($sformatf("response %0d tag", respCount), headTag, respTag);
                respCount++;
            end
        end
    end

    initial begin
        int waitCycles;
        int gap;
        int idx;
        rst           = 1'b1;
        rdy           = 1'b1;
        memWait       = '0;
        reqEn         = 1'b0;
        reqOp         = opLoad;
        reqAddr       = '0;
        reqData       = '0;
        reqLen        = lenByte;
        reqTag        = '0;
        sawFull       = 1'b0;
        respCount     = 0;
        vectorsLoaded = 1'b0;
        void'($urandom(49));

        loadVectors();
        if (vecCount == 0) begin
            reportFailure("no vectors read from testbench/lsu_vectors.txt");
        end
        vectorsLoaded = 1'b1;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (reqReady) begin
                reportFailure("reqReady high during reset");
            end
        end
        rst = 1'b0;

        // the path comes up ready and stays quiet with no requests.
        waitCycles = 0;
        while (!reqReady) begin
            if (waitCycles == READY_WAIT) begin
                reportFailure("reqReady did not rise after reset");
            end
            @(posedge clk);
            #DRIVE_DELAY;
            waitCycles++;
        end
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (!reqReady) begin
                reportFailure("reqReady dropped while idle");
            end
        end

        for (idx = 0; idx < vecCount; idx++) begin
            gap = 0;
            if (($urandom % 4) == 0) begin
                gap = $urandom % 3;
            end
            repeat (gap) begin
                idleCycle();
            end
            pushRequest(idx);
        end

        while (respCount < vecCount) begin
            idleCycle();
        end

        // no extra response may follow the last one.
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            reqEn = 1'b0;
            rdy   = 1'b1;
        end

        if (sawFull) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("the load/store buffer never filled during the burst");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        int timeoutCycles;
        wait (vectorsLoaded);
        timeoutCycles = vecCount * CYCLES_PER_VEC * 2 + RESET_CYCLES + READY_WAIT
                        + IDLE_CYCLES + DRAIN_CYCLES;
        repeat (timeoutCycles) begin
            @(posedge clk);
        end
        reportFailure("timeout: responses missing");
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/lsu_pkg.sv
hdl/loadStoreBuffer.sv
dcache/dcache.sv
memCtrl/memCtrl.sv
hdl/lsuTop.sv
testbench/tbClock.sv
testbench/lsuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the load/store path testbench with Verilator and runs it.
# Exits non-zero unless the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/lsuSim

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module lsuTb -f verilog.f --Mdir obj_dir -o lsuSim \
        > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

if ! "$SIM_BIN" > "$SIM_LOG" 2>&1; then
    cat "$SIM_LOG"
    echo "simulation returned an error status, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"

if ! grep -q "^TB PASSED$" "$SIM_LOG"; then
    echo "pass line not found in $SIM_LOG"
    exit 1
fi

exit 0

/* testbench/lsu_vectors.txt */
// op (0 load, 1 store), addr, data, len (0 byte, 1 half, 2 word), tag, expected data, memWait
// a store expects zero data, a load expects the little-endian, zero-extended bytes.
1 00010 DEADBEEF 2 1 00000000 0
0 00010 00000000 2 2 DEADBEEF 0
1 00020 5A5A5AA1 0 3 00000000 1
1 00021 5A5A5AB2 0 4 00000000 1
1 00022 7777C3D4 1 5 00000000 2
0 00020 00000000 2 6 C3D4B2A1 2
0 00023 00000000 0 7 000000C3 3
0 00021 00000000 1 8 0000D4B2 0
1 00040 11223344 2 9 00000000 3
1 00044 55667788 2 A 00000000 3
1 00048 99AABBCC 2 B 00000000 3
1 0004C 0000DDEE 1 C 00000000 3
0 00040 00000000 2 D 11223344 3
0 00044 00000000 2 E 55667788 3
0 0004B 00000000 0 F 00000099 3
0 0004C 00000000 1 0 0000DDEE 3
0 00046 00000000 2 1 BBCC5566 3
1 100FE 0A0B0C0D 2 2 00000000 1
0 00000 00000000 1 3 00000A0B 2
0 1FFFE 00000000 2 4 0A0B0C0D 0
